//--- common/id_defs.svh
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// datapath word
`define DATA_W 32

// register file geometry
`define RADDR_W 5
`define NUM_REGS 32

// one bit per alu operation
`define ALU_OP_W 12

`endif

//--- common/isa_pkg.sv
package isa_pkg;

    // one instruction word in several field layouts
    typedef union packed {
        struct packed {
            logic [5:0] op_31_26;
            logic [3:0] op_25_22;
            logic [1:0] op_21_20;
            logic [4:0] op_19_15;
            logic [4:0] rk;
            logic [4:0] rj;
            logic [4:0] rd;
        } fmt_3r;
        struct packed {
            logic [5:0]  op_31_26;
            logic [3:0]  op_25_22;
            logic [11:0] i12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  op_31_25;
            logic [19:0] i20;
            logic [4:0]  rd;
        } fmt_1ri20;
        // also the 2ri16 offset through offs_lo
        struct packed {
            logic [5:0]  op_31_26;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } fmt_i26;
    } inst_u;

    typedef enum int unsigned {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // bits 31:26
    localparam logic [5:0] OP6_ZERO = 6'h00;
    localparam logic [5:0] OP6_MEM  = 6'h0a;
    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    // bits 31:25
    localparam logic [6:0] OP7_LU12I     = 7'h0a;
    localparam logic [6:0] OP7_PCADDU12I = 7'h0e;

    // bits 25:22
    localparam logic [3:0] OP4_3R     = 4'h0;
    localparam logic [3:0] OP4_SHIFTI = 4'h1;
    localparam logic [3:0] OP4_LDW    = 4'h2;
    localparam logic [3:0] OP4_STW    = 4'h6;
    localparam logic [3:0] OP4_SLTI   = 4'h8;
    localparam logic [3:0] OP4_SLTUI  = 4'h9;
    localparam logic [3:0] OP4_ADDI   = 4'ha;
    localparam logic [3:0] OP4_ANDI   = 4'hd;
    localparam logic [3:0] OP4_ORI    = 4'he;
    localparam logic [3:0] OP4_XORI   = 4'hf;

    // bits 21:20
    localparam logic [1:0] OP2_SHIFTI = 2'h0;
    localparam logic [1:0] OP2_3R     = 2'h1;

    // bits 19:15
    localparam logic [4:0] OP5_ADD  = 5'h00;
    localparam logic [4:0] OP5_SUB  = 5'h02;
    localparam logic [4:0] OP5_SLT  = 5'h04;
    localparam logic [4:0] OP5_SLTU = 5'h05;
    localparam logic [4:0] OP5_NOR  = 5'h08;
    localparam logic [4:0] OP5_AND  = 5'h09;
    localparam logic [4:0] OP5_OR   = 5'h0a;
    localparam logic [4:0] OP5_XOR  = 5'h0b;
    localparam logic [4:0] OP5_SLL  = 5'h0e;
    localparam logic [4:0] OP5_SRL  = 5'h0f;
    localparam logic [4:0] OP5_SRA  = 5'h10;
    localparam logic [4:0] OP5_SLLI = 5'h01;
    localparam logic [4:0] OP5_SRLI = 5'h09;
    localparam logic [4:0] OP5_SRAI = 5'h11;

endpackage

//--- common/pipe_pkg.sv
`include "id_defs.svh"

package pipe_pkg;

    typedef struct packed {
        logic [`DATA_W-1:0] inst;
        logic [`DATA_W-1:0] pc;
    } if_to_id_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        logic [`DATA_W-1:0]   src1;
        logic [`DATA_W-1:0]   src2;
        logic                 rf_we;
        logic [`RADDR_W-1:0]  rf_waddr;
        logic [`DATA_W-1:0]   pc;
        logic                 mem_we;
        logic                 mem_re;
        logic [`DATA_W-1:0]   store_data;
    } id_to_ex_t;

    typedef struct packed {
        logic                we;
        logic [`RADDR_W-1:0] waddr;
        logic [`DATA_W-1:0]  wdata;
    } bypass_t;

    typedef struct packed {
        logic    is_load;
        bypass_t fwd;
    } ex_bypass_t;

    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } branch_t;

    // one-hot branch kind where direct covers b and bl
    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic direct;
        logic jirl;
    } br_kind_t;

    typedef struct packed {
        logic [`ALU_OP_W-1:0] alu_op;
        logic                 src1_is_pc;
        logic                 src2_is_imm;
        logic [`DATA_W-1:0]   imm;
        logic                 need_r1;
        logic                 need_r2;
        logic                 rf_we;
        logic [`RADDR_W-1:0]  rf_waddr;
        logic                 mem_we;
        logic                 mem_re;
        br_kind_t             br_kind;
        // word offset already sign-extended to 26 bits
        logic [25:0]          br_offs;
    } dec_ctrl_t;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module regfile (
    input  logic                clk,
    input  logic [`RADDR_W-1:0] i_raddr1,
    input  logic [`RADDR_W-1:0] i_raddr2,
    output logic [`DATA_W-1:0]  o_rdata1,
    output logic [`DATA_W-1:0]  o_rdata2,
    input  pipe_pkg::bypass_t   i_wr
);

    logic [`DATA_W-1:0] regs [`NUM_REGS];

    // r0 is hardwired and never stored
    always_ff @(posedge clk) begin
        if (i_wr.we && i_wr.waddr != '0) begin
            regs[i_wr.waddr] <= i_wr.wdata;
        end
    end

    // same-cycle write not visible here
    assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- rtl/id_stage/inst_decoder.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module inst_decoder (
    input  isa_pkg::inst_u       i_inst,
    output pipe_pkg::dec_ctrl_t  o_ctrl,
    output logic [`RADDR_W-1:0]  o_raddr1,
    output logic [`RADDR_W-1:0]  o_raddr2
);
    import isa_pkg::*;

    wire [5:0]  op6 = i_inst.fmt_3r.op_31_26;
    wire [3:0]  op4 = i_inst.fmt_3r.op_25_22;
    wire [4:0]  op5 = i_inst.fmt_3r.op_19_15;
    wire [11:0] i12 = i_inst.fmt_2ri12.i12;
    wire [15:0] o16 = i_inst.fmt_i26.offs_lo;

    wire is_3r     = op6 == OP6_ZERO && op4 == OP4_3R && i_inst.fmt_3r.op_21_20 == OP2_3R;
    wire is_shifti = op6 == OP6_ZERO && op4 == OP4_SHIFTI
                     && i_inst.fmt_3r.op_21_20 == OP2_SHIFTI;

    // register alu
    wire inst_add_w  = is_3r && op5 == OP5_ADD;
    wire inst_sub_w  = is_3r && op5 == OP5_SUB;
    wire inst_slt    = is_3r && op5 == OP5_SLT;
    wire inst_sltu   = is_3r && op5 == OP5_SLTU;
    wire inst_nor    = is_3r && op5 == OP5_NOR;
    wire inst_and    = is_3r && op5 == OP5_AND;
    wire inst_or     = is_3r && op5 == OP5_OR;
    wire inst_xor    = is_3r && op5 == OP5_XOR;
    wire inst_sll_w  = is_3r && op5 == OP5_SLL;
    wire inst_srl_w  = is_3r && op5 == OP5_SRL;
    wire inst_sra_w  = is_3r && op5 == OP5_SRA;

    // immediate alu
    wire inst_slli_w = is_shifti && op5 == OP5_SLLI;
    wire inst_srli_w = is_shifti && op5 == OP5_SRLI;
    wire inst_srai_w = is_shifti && op5 == OP5_SRAI;
    wire inst_slti   = op6 == OP6_ZERO && op4 == OP4_SLTI;
    wire inst_sltui  = op6 == OP6_ZERO && op4 == OP4_SLTUI;
    wire inst_addi_w = op6 == OP6_ZERO && op4 == OP4_ADDI;
    wire inst_andi   = op6 == OP6_ZERO && op4 == OP4_ANDI;
    wire inst_ori    = op6 == OP6_ZERO && op4 == OP4_ORI;
    wire inst_xori   = op6 == OP6_ZERO && op4 == OP4_XORI;
    wire inst_lu12i  = i_inst.fmt_1ri20.op_31_25 == OP7_LU12I;
    wire inst_pcaddu = i_inst.fmt_1ri20.op_31_25 == OP7_PCADDU12I;

    wire inst_ld_w   = op6 == OP6_MEM && op4 == OP4_LDW;
    wire inst_st_w   = op6 == OP6_MEM && op4 == OP4_STW;

    wire inst_jirl   = op6 == OP6_JIRL;
    wire inst_b      = op6 == OP6_B;
    wire inst_bl     = op6 == OP6_BL;
    wire inst_beq    = op6 == OP6_BEQ;
    wire inst_bne    = op6 == OP6_BNE;
    wire inst_blt    = op6 == OP6_BLT;
    wire inst_bge    = op6 == OP6_BGE;
    wire inst_bltu   = op6 == OP6_BLTU;
    wire inst_bgeu   = op6 == OP6_BGEU;

    wire is_cond   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire is_reg    = is_3r & (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                     | inst_and | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w);
    wire is_shi    = inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_si12   = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    wire is_ui12   = inst_andi | inst_ori | inst_xori;
    wire is_u20    = inst_lu12i | inst_pcaddu;
    wire is_link   = inst_jirl | inst_bl;
    wire known     = is_reg | is_shi | is_si12 | is_ui12 | is_u20 | is_link | inst_b | is_cond;

    assign o_raddr1 = i_inst.fmt_3r.rj;
    // stores and compares read rd as the second source
    assign o_raddr2 = (inst_st_w | is_cond) ? i_inst.fmt_3r.rd : i_inst.fmt_3r.rk;

    always_comb begin
        o_ctrl = '0;
        if (known) begin
            o_ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                      | is_link | inst_pcaddu;
            o_ctrl.alu_op[ALU_SUB]  = inst_sub_w;
            o_ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
            o_ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
            o_ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
            o_ctrl.alu_op[ALU_NOR]  = inst_nor;
            o_ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
            o_ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
            o_ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
            o_ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
            o_ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
            o_ctrl.alu_op[ALU_LUI]  = inst_lu12i;

            o_ctrl.src1_is_pc  = is_link | inst_pcaddu;
            o_ctrl.src2_is_imm = is_shi | is_si12 | is_ui12 | is_u20 | is_link;
            if (is_link) begin
                o_ctrl.imm = `DATA_W'd4;
            end else if (is_u20) begin
                o_ctrl.imm = {i_inst.fmt_1ri20.i20, 12'b0};
            end else if (is_si12) begin
                o_ctrl.imm = {{20{i12[11]}}, i12};
            end else if (is_shi) begin
                o_ctrl.imm = {27'b0, i_inst.fmt_3r.rk};
            end else if (is_ui12) begin
                o_ctrl.imm = {20'b0, i12};
            end

            o_ctrl.need_r1  = is_reg | is_shi | is_si12 | is_ui12 | is_cond | inst_jirl;
            o_ctrl.need_r2  = is_reg | inst_st_w | is_cond;
            o_ctrl.rf_we    = ~(inst_st_w | is_cond | inst_b);
            o_ctrl.rf_waddr = inst_bl ? `RADDR_W'd1 : i_inst.fmt_3r.rd;
            o_ctrl.mem_we   = inst_st_w;
            o_ctrl.mem_re   = inst_ld_w;

            o_ctrl.br_kind = '{beq: inst_beq, bne: inst_bne, blt: inst_blt, bge: inst_bge,
                               bltu: inst_bltu, bgeu: inst_bgeu, direct: inst_b | inst_bl,
                               jirl: inst_jirl};
            o_ctrl.br_offs = (inst_b | inst_bl) ? {i_inst.fmt_i26.offs_hi, o16}
                                                : {{10{o16[15]}}, o16};
        end
    end

endmodule

//--- rtl/id_stage/operand_bypass.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module operand_bypass (
    input  logic [`RADDR_W-1:0]  i_raddr1,
    input  logic [`RADDR_W-1:0]  i_raddr2,
    input  logic [`DATA_W-1:0]   i_rdata1,
    input  logic [`DATA_W-1:0]   i_rdata2,
    input  logic                 i_need_r1,
    input  logic                 i_need_r2,
    input  pipe_pkg::ex_bypass_t i_ex_fwd,
    input  pipe_pkg::bypass_t    i_mem_fwd,
    input  pipe_pkg::bypass_t    i_wb_fwd,
    output logic [`DATA_W-1:0]   o_val1,
    output logic [`DATA_W-1:0]   o_val2,
    output logic                 o_stall
);
    import pipe_pkg::*;

    // r0 is never forwarded
    function automatic logic hit(input bypass_t fwd, input logic [`RADDR_W-1:0] addr);
        return fwd.we && (fwd.waddr == addr) && (addr != '0);
    endfunction

    function automatic logic [`DATA_W-1:0] pick(
        input logic [`RADDR_W-1:0] addr,
        input logic [`DATA_W-1:0]  rf_val,
        input bypass_t             ex,
        input bypass_t             mem,
        input bypass_t             wb
    );
        logic [`DATA_W-1:0] val;
        if (hit(ex, addr)) begin
            val = ex.wdata;
        end else if (hit(mem, addr)) begin
            val = mem.wdata;
        end else if (hit(wb, addr)) begin
            val = wb.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    logic ex_hit1;
    logic ex_hit2;

    assign o_val1 = pick(i_raddr1, i_rdata1, i_ex_fwd.fwd, i_mem_fwd, i_wb_fwd);
    assign o_val2 = pick(i_raddr2, i_rdata2, i_ex_fwd.fwd, i_mem_fwd, i_wb_fwd);

    assign ex_hit1 = hit(i_ex_fwd.fwd, i_raddr1) & i_need_r1;
    assign ex_hit2 = hit(i_ex_fwd.fwd, i_raddr2) & i_need_r2;

    // load data not ready until mem
    assign o_stall = i_ex_fwd.is_load & (ex_hit1 | ex_hit2);

endmodule

//--- rtl/id_stage/branch_unit.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module branch_unit (
    input  pipe_pkg::dec_ctrl_t i_ctrl,
    input  logic [`DATA_W-1:0]  i_pc,
    input  logic [`DATA_W-1:0]  i_val1,
    input  logic [`DATA_W-1:0]  i_val2,
    input  logic                i_fire,
    output pipe_pkg::branch_t   o_br
);
    import pipe_pkg::*;

    logic [`DATA_W:0]   diff;
    logic               eq;
    logic               lt_s;
    logic               lt_u;
    logic               ovf;
    logic               cond;
    logic [`DATA_W-1:0] offs;
    br_kind_t           k;

    assign k = i_ctrl.br_kind;

    // rj - rd with borrow out on top
    assign diff = {1'b0, i_val1} - {1'b0, i_val2};
    assign eq   = diff[`DATA_W-1:0] == '0;
    assign lt_u = diff[`DATA_W];
    assign ovf  = (i_val1[`DATA_W-1] ^ i_val2[`DATA_W-1])
                  & (i_val1[`DATA_W-1] ^ diff[`DATA_W-1]);
    assign lt_s = diff[`DATA_W-1] ^ ovf;

    assign cond = (k.beq  &  eq)
                | (k.bne  & ~eq)
                | (k.blt  &  lt_s)
                | (k.bge  & ~lt_s)
                | (k.bltu &  lt_u)
                | (k.bgeu & ~lt_u)
                | k.direct
                | k.jirl;

    // word offset to byte offset
    assign offs = {{4{i_ctrl.br_offs[25]}}, i_ctrl.br_offs, 2'b00};

    assign o_br.taken  = cond & i_fire;
    assign o_br.target = k.jirl ? i_val1 + offs : i_pc + offs;

endmodule

//--- rtl/id_stage/id_stage.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module id_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  pipe_pkg::if_to_id_t  i_if,
    input  logic                 i_if_valid,
    output logic                 o_id_ready,
    output pipe_pkg::id_to_ex_t  o_ex,
    output logic                 o_ex_valid,
    input  logic                 i_ex_ready,
    input  pipe_pkg::ex_bypass_t i_ex_fwd,
    input  pipe_pkg::bypass_t    i_mem_fwd,
    input  pipe_pkg::bypass_t    i_wb_fwd,
    output pipe_pkg::branch_t    o_br
);
    import pipe_pkg::*;

    logic                valid_q;
    if_to_id_t           if_q;
    dec_ctrl_t           ctrl;
    logic [`RADDR_W-1:0] raddr1;
    logic [`RADDR_W-1:0] raddr2;
    logic [`DATA_W-1:0]  rdata1;
    logic [`DATA_W-1:0]  rdata2;
    logic [`DATA_W-1:0]  val1;
    logic [`DATA_W-1:0]  val2;
    logic                stall;
    logic                fire;

    assign o_ex_valid = valid_q & ~stall;
    assign fire       = o_ex_valid & i_ex_ready;
    assign o_id_ready = ~valid_q | fire;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (o_br.taken) begin
            // wrong-path item from IF is dropped here
            valid_q <= 1'b0;
        end else if (o_id_ready) begin
            valid_q <= i_if_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_if_valid && o_id_ready) begin
            if_q <= i_if;
        end
    end

    inst_decoder u_inst_decoder (
        .i_inst   (if_q.inst),
        .o_ctrl   (ctrl),
        .o_raddr1 (raddr1),
        .o_raddr2 (raddr2)
    );

    regfile u_regfile (
        .clk      (clk),
        .i_raddr1 (raddr1),
        .i_raddr2 (raddr2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2),
        .i_wr     (i_wb_fwd)
    );

    operand_bypass u_operand_bypass (
        .i_raddr1  (raddr1),
        .i_raddr2  (raddr2),
        .i_rdata1  (rdata1),
        .i_rdata2  (rdata2),
        .i_need_r1 (ctrl.need_r1),
        .i_need_r2 (ctrl.need_r2),
        .i_ex_fwd  (i_ex_fwd),
        .i_mem_fwd (i_mem_fwd),
        .i_wb_fwd  (i_wb_fwd),
        .o_val1    (val1),
        .o_val2    (val2),
        .o_stall   (stall)
    );

    branch_unit u_branch_unit (
        .i_ctrl (ctrl),
        .i_pc   (if_q.pc),
        .i_val1 (val1),
        .i_val2 (val2),
        .i_fire (fire),
        .o_br   (o_br)
    );

    assign o_ex.alu_op     = ctrl.alu_op;
    assign o_ex.src1       = ctrl.src1_is_pc ? if_q.pc : val1;
    assign o_ex.src2       = ctrl.src2_is_imm ? ctrl.imm : val2;
    assign o_ex.rf_we      = ctrl.rf_we;
    assign o_ex.rf_waddr   = ctrl.rf_waddr;
    assign o_ex.pc         = if_q.pc;
    assign o_ex.mem_we     = ctrl.mem_we;
    assign o_ex.mem_re     = ctrl.mem_re;
    assign o_ex.store_data = val2;

endmodule

//--- verif/tb_id_stage.sv
`timescale 1ns/100ps
`include "id_defs.svh"

module tb_id_stage;
    import pipe_pkg::*;

    // kinds 0..10 register alu, 11..23 immediate and memory, 24 unknown, 25..33 branches
    localparam int K_LDW   = 22;
    localparam int K_STW   = 23;
    localparam int K_BAD   = 24;
    localparam int K_B     = 31;
    localparam int K_BL    = 32;
    localparam int K_JIRL  = 33;

    logic       clk;
    logic       resetn;
    if_to_id_t  i_if;
    logic       i_if_valid;
    logic       o_id_ready;
    id_to_ex_t  o_ex;
    logic       o_ex_valid;
    logic       i_ex_ready;
    ex_bypass_t i_ex_fwd;
    bypass_t    i_mem_fwd;
    bypass_t    i_wb_fwd;
    branch_t    o_br;

    logic [31:0] lfsr;
    logic [31:0] mrf [32];
    logic        m_valid;
    int          m_kind;
    logic [31:0] m_word;
    logic [31:0] m_pc;
    int          off_kind;
    logic [31:0] off_word;
    logic [31:0] off_pc;

    logic                 e_valid, e_ready, e_fire, e_taken, e_stall;
    logic                 e_we, e_mem_we, e_mem_re;
    logic [4:0]           e_waddr;
    logic [`ALU_OP_W-1:0] e_alu;
    logic [31:0]          e_src1, e_src2, e_store, e_target;

    string cur_test;
    int    cfg_lo, cfg_hi, cfg_tight, cfg_load, cfg_ready, cfg_pre;
    int    n_out, n_tests, n_checks, n_errors;

    id_stage i_id_stage (
        .clk        (clk),
        .resetn     (resetn),
        .i_if       (i_if),
        .i_if_valid (i_if_valid),
        .o_id_ready (o_id_ready),
        .o_ex       (o_ex),
        .o_ex_valid (o_ex_valid),
        .i_ex_ready (i_ex_ready),
        .i_ex_fwd   (i_ex_fwd),
        .i_mem_fwd  (i_mem_fwd),
        .i_wb_fwd   (i_wb_fwd),
        .o_br       (o_br)
    );

    always #4 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic logic [31:0] encode(input int k, input logic [25:0] r);
        logic [31:0] w;
        case (k)
            0:  w = {12'h001, 5'h00, r[14:0]};
            1:  w = {12'h001, 5'h02, r[14:0]};
            2:  w = {12'h001, 5'h04, r[14:0]};
            3:  w = {12'h001, 5'h05, r[14:0]};
            4:  w = {12'h001, 5'h09, r[14:0]};
            5:  w = {12'h001, 5'h08, r[14:0]};
            6:  w = {12'h001, 5'h0a, r[14:0]};
            7:  w = {12'h001, 5'h0b, r[14:0]};
            8:  w = {12'h001, 5'h0e, r[14:0]};
            9:  w = {12'h001, 5'h0f, r[14:0]};
            10: w = {12'h001, 5'h10, r[14:0]};
            11: w = {10'h008, r[21:0]};
            12: w = {10'h009, r[21:0]};
            13: w = {10'h00a, r[21:0]};
            14: w = {10'h00d, r[21:0]};
            15: w = {10'h00e, r[21:0]};
            16: w = {10'h00f, r[21:0]};
            17: w = {12'h004, 5'h01, r[14:0]};
            18: w = {12'h004, 5'h09, r[14:0]};
            19: w = {12'h004, 5'h11, r[14:0]};
            20: w = {7'h0a, r[24:0]};
            21: w = {7'h0e, r[24:0]};
            22: w = {10'h0a2, r[21:0]};
            23: w = {10'h0a6, r[21:0]};
            25: w = {6'h16, r};
            26: w = {6'h17, r};
            27: w = {6'h18, r};
            28: w = {6'h19, r};
            29: w = {6'h1a, r};
            30: w = {6'h1b, r};
            31: w = {6'h14, r};
            32: w = {6'h15, r};
            33: w = {6'h13, r};
            default: w = {6'h3f, r};
        endcase
        return w;
    endfunction

    // bit of the one-hot alu word or -1 for none
    function automatic int alu_bit(input int k);
        case (k)
            11: return 2;
            12: return 3;
            13: return 0;
            14: return 4;
            15: return 6;
            16: return 7;
            17: return 8;
            18: return 9;
            19: return 10;
            20: return 11;
            21, 22, 23, 32, 33: return 0;
            default: return (k <= 10) ? k : -1;
        endcase
    endfunction

    function automatic logic [31:0] fwd(input logic [4:0] a);
        logic [31:0] v;
        if (a == 0) begin
            v = '0;
        end else if (i_ex_fwd.fwd.we && i_ex_fwd.fwd.waddr == a) begin
            v = i_ex_fwd.fwd.wdata;
        end else if (i_mem_fwd.we && i_mem_fwd.waddr == a) begin
            v = i_mem_fwd.wdata;
        end else if (i_wb_fwd.we && i_wb_fwd.waddr == a) begin
            v = i_wb_fwd.wdata;
        end else begin
            v = mrf[a];
        end
        return v;
    endfunction

    function automatic bypass_t rand_fwd();
        bypass_t f;
        f.we    = rnd(1);
        f.waddr = cfg_tight ? rnd(2) : rnd(5);
        f.wdata = cfg_tight ? rnd(2) : rnd(32);
        return f;
    endfunction

    task automatic eval();
        logic [4:0]  rd, rj, r2;
        logic [31:0] v1, v2, imm, offs;
        logic        is_cond, need1, need2, cond;
        int          k, b;
        k       = m_kind;
        rd      = m_word[4:0];
        rj      = m_word[9:5];
        is_cond = k >= 25 && k <= 30;
        r2      = (k == K_STW || is_cond) ? rd : m_word[14:10];
        v1      = fwd(rj);
        v2      = fwd(r2);
        need1   = k <= 19 || k == K_LDW || k == K_STW || is_cond || k == K_JIRL;
        need2   = k <= 10 || k == K_STW || is_cond;
        e_stall = i_ex_fwd.is_load && i_ex_fwd.fwd.we && i_ex_fwd.fwd.waddr != 0
                  && ((need1 && i_ex_fwd.fwd.waddr == rj) || (need2 && i_ex_fwd.fwd.waddr == r2));
        case (k)
            11, 12, 13, 22, 23: imm = {{20{m_word[21]}}, m_word[21:10]};
            14, 15, 16: imm = {20'b0, m_word[21:10]};
            17, 18, 19: imm = {27'b0, m_word[14:10]};
            20, 21: imm = {m_word[24:5], 12'b0};
            default: imm = 32'd4;
        endcase
        b        = alu_bit(k);
        e_alu    = (b >= 0) ? `ALU_OP_W'(1) << b : '0;
        e_src1   = (k == 21 || k == K_BL || k == K_JIRL) ? m_pc : v1;
        e_src2   = ((k >= 11 && k <= K_STW) || k == K_BL || k == K_JIRL) ? imm : v2;
        e_store  = v2;
        e_we     = !(k == K_STW || k == K_BAD || (k >= 25 && k <= K_B));
        e_waddr  = (k == K_BL) ? 5'd1 : rd;
        e_mem_we = k == K_STW;
        e_mem_re = k == K_LDW;
        case (k)
            25: cond = v1 == v2;
            26: cond = v1 != v2;
            27: cond = $signed(v1) < $signed(v2);
            28: cond = $signed(v1) >= $signed(v2);
            29: cond = v1 < v2;
            30: cond = v1 >= v2;
            31, 32, 33: cond = 1'b1;
            default: cond = 1'b0;
        endcase
        if (k == K_B || k == K_BL) begin
            offs = {{4{m_word[9]}}, m_word[9:0], m_word[25:10], 2'b00};
        end else begin
            offs = {{14{m_word[25]}}, m_word[25:10], 2'b00};
        end
        e_target = (k == K_JIRL) ? v1 + offs : m_pc + offs;
        e_valid  = m_valid && !e_stall;
        e_fire   = e_valid && i_ex_ready;
        e_ready  = !m_valid || e_fire;
        e_taken  = e_fire && cond;
    endtask

    task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
        n_errors++;
        $display("** Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    endtask

    task automatic check_outputs();
        eval();
        n_checks++;
        if (o_ex_valid !== e_valid) begin
            report("o_ex_valid", e_valid, o_ex_valid);
        end
        if (o_id_ready !== e_ready) begin
            report("o_id_ready", e_ready, o_id_ready);
        end
        if (o_br.taken !== e_taken) begin
            report("o_br.taken", e_taken, o_br.taken);
        end
        if (e_taken && o_br.target !== e_target) begin
            report("o_br.target", e_target, o_br.target);
        end
        if (e_valid && o_ex_valid) begin
            if (o_ex.alu_op !== e_alu) begin
                report("alu_op", e_alu, o_ex.alu_op);
            end
            if ((m_kind <= K_STW || m_kind >= K_BL) && o_ex.src1 !== e_src1) begin
                report("src1", e_src1, o_ex.src1);
            end
            if ((m_kind <= K_STW || m_kind >= K_BL) && o_ex.src2 !== e_src2) begin
                report("src2", e_src2, o_ex.src2);
            end
            if (o_ex.rf_we !== e_we) begin
                report("rf_we", e_we, o_ex.rf_we);
            end
            if (e_we && o_ex.rf_waddr !== e_waddr) begin
                report("rf_waddr", e_waddr, o_ex.rf_waddr);
            end
            if (o_ex.mem_we !== e_mem_we || o_ex.mem_re !== e_mem_re) begin
                report("mem_we/mem_re", {e_mem_we, e_mem_re}, {o_ex.mem_we, o_ex.mem_re});
            end
            if (m_kind == K_STW && o_ex.store_data !== e_store) begin
                report("store_data", e_store, o_ex.store_data);
            end
            if (o_ex.pc !== m_pc) begin
                report("pc", m_pc, o_ex.pc);
            end
        end
    endtask

    task automatic drive();
        logic [25:0] r;
        if (cfg_pre != 0) begin
            i_if_valid     = 1'b0;
            i_ex_ready     = 1'b1;
            i_ex_fwd       = '0;
            i_mem_fwd      = '0;
            i_wb_fwd.we    = 1'b1;
            i_wb_fwd.waddr = cfg_pre[4:0];
            i_wb_fwd.wdata = rnd(32);
        end else begin
            off_kind = cfg_lo + rnd(8) % (cfg_hi - cfg_lo + 1);
            r        = rnd(26);
            // squeeze rd, rj and rk into r0..r3 so bypasses collide
            if (cfg_tight != 0) begin
                r[4:2]   = '0;
                r[9:7]   = '0;
                r[14:12] = '0;
            end
            off_word         = encode(off_kind, r);
            off_pc           = rnd(30) << 2;
            i_if.inst        = off_word;
            i_if.pc          = off_pc;
            i_if_valid       = rnd(2) != 0;
            i_ex_ready       = rnd(3) < cfg_ready;
            i_ex_fwd.is_load = rnd(3) < cfg_load;
            i_ex_fwd.fwd     = rand_fwd();
            i_mem_fwd        = rand_fwd();
            i_wb_fwd         = rand_fwd();
        end
    endtask

    task automatic update();
        if (e_fire) begin
            n_out++;
        end
        if (e_taken) begin
            m_valid = 1'b0;
        end else if (e_ready) begin
            m_valid = i_if_valid;
            if (i_if_valid) begin
                m_kind = off_kind;
                m_word = off_word;
                m_pc   = off_pc;
            end
        end
        if (i_wb_fwd.we && i_wb_fwd.waddr != 0) begin
            mrf[i_wb_fwd.waddr] = i_wb_fwd.wdata;
        end
    endtask

    task automatic step();
        @(negedge clk);
        drive();
        #2;
        check_outputs();
        @(posedge clk);
        update();
    endtask

    task automatic run_test(input string name, input int lo, input int hi, input int tight,
                            input int load, input int ready, input int items);
        int cycles;
        int err0;
        cur_test  = name;
        cfg_lo    = lo;
        cfg_hi    = hi;
        cfg_tight = tight;
        cfg_load  = load;
        cfg_ready = ready;
        cfg_pre   = 0;
        err0      = n_errors;
        n_out     = 0;
        cycles    = 0;
        while (n_out < items && cycles < items * 20) begin
            step();
            cycles++;
        end
        if (n_out < items) begin
            n_errors++;
            $display("%s: timed out after %0d cycles, only %0d of %0d items reached EX",
                     name, cycles, n_out, items);
        end
        $display("test %-12s %0d items, %0d errors", name, n_out, n_errors - err0);
        n_tests++;
    endtask

    initial begin
        lfsr       = 32'hd240_c0c4;
        clk        = 1'b0;
        resetn     = 1'b0;
        i_if       = '0;
        i_if_valid = 1'b0;
        i_ex_ready = 1'b0;
        i_ex_fwd   = '0;
        i_mem_fwd  = '0;
        i_wb_fwd   = '0;
        m_valid    = 1'b0;
        m_kind     = K_BAD;
        m_word     = '0;
        m_pc       = '0;
        n_tests    = 0;
        n_checks   = 0;
        n_errors   = 0;
        for (int a = 0; a < 32; a++) begin
            mrf[a] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        // idle stage while WB fills r1..r31
        cur_test = "reset";
        for (int a = 1; a < 32; a++) begin
            cfg_pre = a;
            step();
        end
        $display("test %-12s %0d items, %0d errors", cur_test, 0, n_errors);
        n_tests++;

        run_test("decode", 0, K_BAD, 0, 1, 8, 200);
        run_test("bypass", 0, K_BAD, 1, 0, 8, 200);
        run_test("load_use", 0, K_BAD, 1, 4, 8, 150);
        run_test("branch", 25, K_JIRL, 1, 1, 6, 150);
        run_test("backpressure", 0, K_JIRL, 1, 2, 4, 200);

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/regfile.sv
rtl/id_stage/inst_decoder.sv
rtl/id_stage/operand_bypass.sv
rtl/id_stage/branch_unit.sv
rtl/id_stage/id_stage.sv
verif/tb_id_stage.sv
